/* hw/tunnel_config.svh */
// 640x480 raster with 800x525 total positions; geometry assumes diagonals run top to bottom
`ifndef TUNNEL_CONFIG_SVH
`define TUNNEL_CONFIG_SVH

`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// upper-left x, upper-left y, width, height; outermost first
`define FRAME_COUNT 9
`define FRAME_TABLE '{ \
	'{ 63,  47, 514, 386}, '{ 99,  74, 442, 332}, '{133, 100, 374, 281}, \
	'{163, 122, 314, 236}, '{189, 142, 263, 197}, '{211, 158, 218, 164}, \
	'{229, 172, 182, 137}, '{243, 182, 154, 116}, '{255, 191, 130,  98}}

// diagonal endpoints, from corner (X0,Y0) to corner (X1,Y1)
`define DIAG_UL_X0 63
`define DIAG_UL_Y0 47
`define DIAG_UL_X1 255
`define DIAG_UL_Y1 191
`define DIAG_LR_X0 384
`define DIAG_LR_Y0 288
`define DIAG_LR_X1 576
`define DIAG_LR_Y1 432
`define DIAG_LL_X0 255
`define DIAG_LL_Y0 288
`define DIAG_LL_X1 63
`define DIAG_LL_Y1 432
`define DIAG_UR_X0 576
`define DIAG_UR_Y0 47
`define DIAG_UR_X1 384
`define DIAG_UR_Y1 191

`define SCORE_X_LEFT 64
`define SCORE_X_RIGHT 544
`define SCORE_Y 10
`define GLYPH_SCALE 4

`define COLOR_LINE 24'h00FF00
`define COLOR_SCORE 24'h66FFFF
`define COLOR_BG 24'h000000

`endif

/* hw/tunnel_pkg.sv */
// digit font covers 0 to 9 only; callers must treat digits 10 to 15 as blank
package tunnel_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [23:0] color_t;
	typedef logic [3:0] digit_t;
	// leftmost pixel in the msb
	typedef logic [7:0] glyph_row_t;

	localparam glyph_row_t digit_font [10][8] = '{
		'{8'h3C, 8'h66, 8'h6E, 8'h76, 8'h66, 8'h66, 8'h3C, 8'h00},
		'{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
		'{8'h3C, 8'h66, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E, 8'h00},
		'{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
		'{8'h0C, 8'h1C, 8'h3C, 8'h6C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
		'{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
		'{8'h3C, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h66, 8'h3C, 8'h00},
		'{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
		'{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
		'{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h0C, 8'h38, 8'h00}
	};

endpackage

/* hw/raster_if.sv */
// one source drives the scan position; strobes are already qualified by the pixel strobe
`timescale 1ns/100ps

interface raster_if;
	import tunnel_pkg::*;

	coord_t x;
	coord_t y;
	logic active;
	logic step;
	logic line_end;
	logic frame_start;

	modport source (output x, y, active, step, line_end, frame_start);
	modport sink (input x, y, active, step, line_end, frame_start);

endinterface

/* hw/raster_timing.sv */
// counters advance only when pix_en is high; syncs are active low and combinational
`timescale 1ns/100ps
`include "tunnel_config.svh"

module raster_timing (
	input logic clk,
	input logic rst,
	input logic pix_en,
	raster_if.source rif,
	output logic hsync,
	output logic vsync
);
	import tunnel_pkg::*;

	localparam coord_t H_LAST = coord_t'(`H_TOTAL - 1);
	localparam coord_t V_LAST = coord_t'(`V_TOTAL - 1);
	localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FRONT);
	localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FRONT);

	coord_t h_cnt;
	coord_t v_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_en) begin
			if (h_cnt == H_LAST) begin
				h_cnt <= '0;
				v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	assign hsync = !(h_cnt >= HS_START && h_cnt < HS_START + coord_t'(`H_SYNC));
	assign vsync = !(v_cnt >= VS_START && v_cnt < VS_START + coord_t'(`V_SYNC));

	assign rif.x = h_cnt;
	assign rif.y = v_cnt;
	assign rif.active = (h_cnt < coord_t'(`H_ACTIVE)) && (v_cnt < coord_t'(`V_ACTIVE));
	assign rif.step = pix_en;
	// last visible column, on every line
	assign rif.line_end = pix_en && (h_cnt == coord_t'(`H_ACTIVE - 1));
	assign rif.frame_start = pix_en && (h_cnt == '0) && (v_cnt == '0);

endmodule

/* hw/frame_draw.sv */
// outlines are one pixel wide; frame geometry comes from the shared table
`timescale 1ns/100ps
`include "tunnel_config.svh"

module frame_draw (
	raster_if.sink rif,
	output logic hit
);
	localparam int NUM_FRAMES = `FRAME_COUNT;
	localparam int FRAMES [NUM_FRAMES][4] = `FRAME_TABLE;

	always_comb begin
		int px;
		int py;
		px = int'(rif.x);
		py = int'(rif.y);
		hit = 1'b0;
		for (int i = 0; i < NUM_FRAMES; i++) begin
			// top and bottom rows
			if ((py == FRAMES[i][1] || py == FRAMES[i][1] + FRAMES[i][3] - 1) &&
			    px >= FRAMES[i][0] && px < FRAMES[i][0] + FRAMES[i][2])
				hit = 1'b1;
			// left and right columns
			if ((px == FRAMES[i][0] || px == FRAMES[i][0] + FRAMES[i][2] - 1) &&
			    py >= FRAMES[i][1] && py < FRAMES[i][1] + FRAMES[i][3])
				hit = 1'b1;
		end
	end

endmodule

/* hw/diagonal_draw.sv */
// Y_FROM must not exceed Y_TO; slope is fixed at three lines per four columns
`timescale 1ns/100ps
`include "tunnel_config.svh"

module diagonal_draw #(
	parameter int X_FROM = 63,
	parameter int Y_FROM = 47,
	parameter int X_TO = 255,
	parameter int Y_TO = 191,
	parameter bit LEFTWARD = 1'b0
) (
	input logic clk,
	input logic rst,
	raster_if.sink rif,
	output logic hit
);
	import tunnel_pkg::*;

	// line just above the span, wrapping into the blanking lines
	localparam int Y_PREV = (Y_FROM == 0) ? `V_TOTAL - 1 : Y_FROM - 1;
	localparam coord_t X_LO = coord_t'(LEFTWARD ? X_TO : X_FROM);
	localparam coord_t X_HI = coord_t'(LEFTWARD ? X_FROM : X_TO);

	coord_t run_start;
	coord_t run_step;
	logic [1:0] line_mod3;
	logic in_span;
	logic in_box;

	assign run_step = (line_mod3 == 2'd2) ? coord_t'(2) : coord_t'(1);
	assign in_span = (rif.y >= coord_t'(Y_FROM)) && (rif.y <= coord_t'(Y_TO));
	assign in_box = in_span && (rif.x >= X_LO) && (rif.x <= X_HI);

	always_ff @(posedge clk) begin
		if (rst) begin
			run_start <= coord_t'(X_FROM);
			line_mod3 <= '0;
		end else if (rif.step && rif.y == coord_t'(Y_PREV)) begin
			run_start <= coord_t'(X_FROM);
			line_mod3 <= '0;
		end else if (rif.line_end && in_span) begin
			run_start <= LEFTWARD ? run_start - run_step : run_start + run_step;
			line_mod3 <= (line_mod3 == 2'd2) ? 2'd0 : line_mod3 + 1'b1;
		end
	end

	// run of run_step+1 pixels away from the start column
	always_comb begin
		if (LEFTWARD)
			hit = in_box && (rif.x <= run_start) && (rif.x + run_step >= run_start);
		else
			hit = in_box && (rif.x >= run_start) && (rif.x <= run_start + run_step);
	end

endmodule

/* hw/glyph_rom.sv */
// one clock of read latency; digits 10 to 15 read as an empty row
`timescale 1ns/100ps

module glyph_rom (
	input logic clk,
	input tunnel_pkg::digit_t digit,
	input logic [2:0] row,
	output tunnel_pkg::glyph_row_t bits
);
	import tunnel_pkg::*;

	logic blank;

	assign blank = (digit > digit_t'(9));

	always_ff @(posedge clk) begin
		if (blank)
			bits <= '0;
		else
			bits <= digit_font[digit][row];
	end

endmodule

/* hw/score_draw.sv */
// scores sampled at frame start; ROM address tracks the pixel shown in the following cycle
`timescale 1ns/100ps
`include "tunnel_config.svh"

module score_draw (
	input logic clk,
	input logic rst,
	raster_if.sink rif,
	input tunnel_pkg::digit_t your_score,
	input tunnel_pkg::digit_t their_score,
	output logic hit
);
	import tunnel_pkg::*;

	localparam int BOX = 8 * `GLYPH_SCALE;
	localparam coord_t LEFT_X = coord_t'(`SCORE_X_LEFT);
	localparam coord_t RIGHT_X = coord_t'(`SCORE_X_RIGHT);
	localparam coord_t TOP_Y = coord_t'(`SCORE_Y);
	localparam coord_t SCALE = coord_t'(`GLYPH_SCALE);

	digit_t left_digit;
	digit_t right_digit;
	digit_t rom_digit;
	coord_t next_x;
	coord_t next_y;
	coord_t row_full;
	coord_t col_full;
	glyph_row_t rom_bits;
	logic in_rows;
	logic in_left;
	logic in_right;

	always_ff @(posedge clk) begin
		if (rst) begin
			left_digit <= '1;
			right_digit <= '1;
		end else if (rif.frame_start) begin
			left_digit <= your_score;
			right_digit <= their_score;
		end
	end

	// position on raster_if after this clock edge
	always_comb begin
		next_x = rif.x;
		next_y = rif.y;
		if (rif.step) begin
			if (rif.x == coord_t'(`H_TOTAL - 1)) begin
				next_x = '0;
				next_y = (rif.y == coord_t'(`V_TOTAL - 1)) ? '0 : rif.y + 1'b1;
			end else begin
				next_x = rif.x + 1'b1;
			end
		end
	end

	assign rom_digit = (next_x < RIGHT_X) ? left_digit : right_digit;
	assign row_full = (next_y - TOP_Y) / SCALE;

	glyph_rom u_rom (
		.clk(clk),
		.digit(rom_digit),
		.row(row_full[2:0]),
		.bits(rom_bits)
	);

	assign in_rows = (rif.y >= TOP_Y) && (rif.y < TOP_Y + coord_t'(BOX));
	assign in_left = (rif.x >= LEFT_X) && (rif.x < LEFT_X + coord_t'(BOX));
	assign in_right = (rif.x >= RIGHT_X) && (rif.x < RIGHT_X + coord_t'(BOX));
	assign col_full = (rif.x - (in_left ? LEFT_X : RIGHT_X)) / SCALE;
	assign hit = in_rows && (in_left || in_right) && rom_bits[3'd7 - col_full[2:0]];

endmodule

/* hw/tunnel_render.sv */
// outputs lag raster_if by one step and hold whenever pix_en is low
`timescale 1ns/100ps
`include "tunnel_config.svh"

module tunnel_render (
	input logic clk,
	input logic rst,
	input logic pix_en,
	input tunnel_pkg::digit_t your_score,
	input tunnel_pkg::digit_t their_score,
	output tunnel_pkg::color_t color,
	output logic hsync,
	output logic vsync,
	output logic de,
	output tunnel_pkg::coord_t pixel_x,
	output tunnel_pkg::coord_t pixel_y
);
	import tunnel_pkg::*;

	raster_if rif ();

	logic raw_hsync;
	logic raw_vsync;
	logic frame_hit;
	logic score_hit;
	logic [3:0] diag_hit;
	color_t color_next;

	raster_timing u_timing (
		.clk(clk),
		.rst(rst),
		.pix_en(pix_en),
		.rif(rif),
		.hsync(raw_hsync),
		.vsync(raw_vsync)
	);

	frame_draw u_frames (
		.rif(rif),
		.hit(frame_hit)
	);

	diagonal_draw #(`DIAG_UL_X0, `DIAG_UL_Y0, `DIAG_UL_X1, `DIAG_UL_Y1, 1'b0) u_diag_ul (
		.clk(clk), .rst(rst), .rif(rif), .hit(diag_hit[0])
	);
	diagonal_draw #(`DIAG_LR_X0, `DIAG_LR_Y0, `DIAG_LR_X1, `DIAG_LR_Y1, 1'b0) u_diag_lr (
		.clk(clk), .rst(rst), .rif(rif), .hit(diag_hit[1])
	);
	diagonal_draw #(`DIAG_LL_X0, `DIAG_LL_Y0, `DIAG_LL_X1, `DIAG_LL_Y1, 1'b1) u_diag_ll (
		.clk(clk), .rst(rst), .rif(rif), .hit(diag_hit[2])
	);
	diagonal_draw #(`DIAG_UR_X0, `DIAG_UR_Y0, `DIAG_UR_X1, `DIAG_UR_Y1, 1'b1) u_diag_ur (
		.clk(clk), .rst(rst), .rif(rif), .hit(diag_hit[3])
	);

	score_draw u_score (
		.clk(clk),
		.rst(rst),
		.rif(rif),
		.your_score(your_score),
		.their_score(their_score),
		.hit(score_hit)
	);

	// lines over score over background
	always_comb begin
		if (!rif.active)
			color_next = `COLOR_BG;
		else if (frame_hit || (|diag_hit))
			color_next = `COLOR_LINE;
		else if (score_hit)
			color_next = `COLOR_SCORE;
		else
			color_next = `COLOR_BG;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			color <= `COLOR_BG;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de <= 1'b0;
			pixel_x <= '0;
			pixel_y <= '0;
		end else if (rif.step) begin
			color <= color_next;
			hsync <= raw_hsync;
			vsync <= raw_vsync;
			de <= rif.active;
			pixel_x <= rif.x;
			pixel_y <= rif.y;
		end
	end

endmodule

/* bench/tunnel_props.sv */
// bound into tunnel_render; hsync width is counted in pixel steps, so pix_en gaps do not stretch it
`timescale 1ns/100ps
`include "tunnel_config.svh"

module tunnel_props (
	input logic clk,
	input logic rst,
	input logic pix_en,
	input logic de,
	input logic hsync,
	input logic vsync,
	input tunnel_pkg::color_t color,
	input tunnel_pkg::coord_t pixel_x,
	input tunnel_pkg::coord_t pixel_y
);
	int low_run;
	int fail_count = 0;

	// low hsync values seen so far in the current pulse
	always_ff @(posedge clk) begin
		if (rst)
			low_run <= 0;
		else if (pix_en)
			low_run <= hsync ? 0 : low_run + 1;
	end

	de_in_active: assert property (@(posedge clk) disable iff (rst)
		de |-> (int'(pixel_x) < `H_ACTIVE && int'(pixel_y) < `V_ACTIVE))
		else begin
			$error("de high outside the active area");
			fail_count++;
		end

	hsync_width: assert property (@(posedge clk) disable iff (rst)
		(pix_en && hsync && low_run != 0) |-> (low_run == `H_SYNC))
		else begin
			$error("hsync pulse was %0d steps long", low_run);
			fail_count++;
		end

	hold_on_gap: assert property (@(posedge clk) disable iff (rst)
		!pix_en |=> ($stable(color) && $stable(de) && $stable(hsync) && $stable(vsync) &&
			$stable(pixel_x) && $stable(pixel_y)))
		else begin
			$error("outputs changed while pix_en was low");
			fail_count++;
		end

endmodule

bind tunnel_render tunnel_props u_props (
	.clk(clk),
	.rst(rst),
	.pix_en(pix_en),
	.de(de),
	.hsync(hsync),
	.vsync(vsync),
	.color(color),
	.pixel_x(pixel_x),
	.pixel_y(pixel_y)
);

/* bench/tunnel_checker.sv */
// compares each stepped output at the falling edge; scores present at the frame start step rule that frame
`timescale 1ns/100ps
`include "tunnel_config.svh"

module tunnel_checker (
	input logic clk,
	input logic rst,
	input logic pix_en,
	input tunnel_pkg::digit_t your_score,
	input tunnel_pkg::digit_t their_score,
	input tunnel_pkg::color_t color,
	input logic hsync,
	input logic vsync,
	input logic de,
	input tunnel_pkg::coord_t pixel_x,
	input tunnel_pkg::coord_t pixel_y,
	output int errors,
	output int teal_count,
	output int hs_pulses,
	output int vs_pulses,
	output int vs_low_steps,
	output int de_lines,
	output int bad_lines
);
	import tunnel_pkg::*;

	localparam int FRAMES [`FRAME_COUNT][4] = `FRAME_TABLE;

	bit rst_q;
	bit step_q;
	digit_t your_at_step;
	digit_t their_at_step;
	int left_d;
	int right_d;
	int exp_x;
	int exp_y;
	int de_run;
	bit hs_prev;
	bit vs_prev;

	// n lines down the span, the run has moved n + n/3 columns
	function automatic bit on_diagonal(int px, int py, int xf, int yf, int xt, int yt);
		int n;
		int start;
		int len;
		if (py < yf || py > yt)
			return 1'b0;
		if (px < (xf < xt ? xf : xt) || px > (xf < xt ? xt : xf))
			return 1'b0;
		n = py - yf;
		len = (n % 3 == 2) ? 3 : 2;
		if (xt < xf) begin
			start = xf - (n + n / 3);
			return px <= start && px > start - len;
		end
		start = xf + (n + n / 3);
		return px >= start && px < start + len;
	endfunction

	function automatic bit on_glyph(int px, int py, int box_x, int digit);
		int col;
		int row;
		glyph_row_t bits;
		if (digit > 9)
			return 1'b0;
		if (px < box_x || px >= box_x + 8 * `GLYPH_SCALE)
			return 1'b0;
		if (py < `SCORE_Y || py >= `SCORE_Y + 8 * `GLYPH_SCALE)
			return 1'b0;
		col = (px - box_x) / `GLYPH_SCALE;
		row = (py - `SCORE_Y) / `GLYPH_SCALE;
		bits = digit_font[digit][row];
		return bits[7 - col];
	endfunction

	function automatic color_t ref_color(int px, int py, int left_digit, int right_digit);
		bit line;
		int x0;
		int y0;
		int x1;
		int y1;
		line = 1'b0;
		for (int i = 0; i < `FRAME_COUNT; i++) begin
			x0 = FRAMES[i][0];
			y0 = FRAMES[i][1];
			x1 = x0 + FRAMES[i][2] - 1;
			y1 = y0 + FRAMES[i][3] - 1;
			if ((py == y0 || py == y1) && px >= x0 && px <= x1)
				line = 1'b1;
			if ((px == x0 || px == x1) && py >= y0 && py <= y1)
				line = 1'b1;
		end
		line |= on_diagonal(px, py, `DIAG_UL_X0, `DIAG_UL_Y0, `DIAG_UL_X1, `DIAG_UL_Y1);
		line |= on_diagonal(px, py, `DIAG_LR_X0, `DIAG_LR_Y0, `DIAG_LR_X1, `DIAG_LR_Y1);
		line |= on_diagonal(px, py, `DIAG_LL_X0, `DIAG_LL_Y0, `DIAG_LL_X1, `DIAG_LL_Y1);
		line |= on_diagonal(px, py, `DIAG_UR_X0, `DIAG_UR_Y0, `DIAG_UR_X1, `DIAG_UR_Y1);
		if (line)
			return `COLOR_LINE;
		if (on_glyph(px, py, `SCORE_X_LEFT, left_digit) ||
		    on_glyph(px, py, `SCORE_X_RIGHT, right_digit))
			return `COLOR_SCORE;
		return `COLOR_BG;
	endfunction

	always @(posedge clk) begin
		rst_q <= rst;
		step_q <= pix_en && !rst;
		if (pix_en) begin
			your_at_step <= your_score;
			their_at_step <= their_score;
		end
	end

	always @(negedge clk) begin
		int bad;
		int px;
		int py;
		color_t expected;
		bad = 0;
		px = int'(pixel_x);
		py = int'(pixel_y);
		if (rst_q) begin
			exp_x = 0;
			exp_y = 0;
			de_run = 0;
			hs_prev = 1'b1;
			vs_prev = 1'b1;
		end else if (step_q) begin
			if (px != exp_x || py != exp_y) begin
				$display("ERROR t=%0t pixel_x/pixel_y expected (%0d,%0d) got (%0d,%0d)",
					$time, exp_x, exp_y, px, py);
				bad++;
			end
			exp_x = (px == `H_TOTAL - 1) ? 0 : px + 1;
			exp_y = (px != `H_TOTAL - 1) ? py : ((py == `V_TOTAL - 1) ? 0 : py + 1);
			if (px == 0 && py == 0) begin
				left_d = int'(your_at_step);
				right_d = int'(their_at_step);
			end
			if (de) begin
				expected = ref_color(px, py, left_d, right_d);
				if (color !== expected) begin
					$display("ERROR t=%0t color at (%0d,%0d) expected %06h got %06h",
						$time, px, py, expected, color);
					bad++;
				end
				if (color == `COLOR_SCORE)
					teal_count <= teal_count + 1;
				de_run++;
			end else if (de_run != 0) begin
				if (de_run != `H_ACTIVE) begin
					$display("ERROR t=%0t de steps on line %0d expected %0d got %0d",
						$time, py, `H_ACTIVE, de_run);
					bad_lines <= bad_lines + 1;
				end
				de_lines <= de_lines + 1;
				de_run = 0;
			end
			if (hs_prev && !hsync)
				hs_pulses <= hs_pulses + 1;
			if (vs_prev && !vsync)
				vs_pulses <= vs_pulses + 1;
			if (!vsync)
				vs_low_steps <= vs_low_steps + 1;
			hs_prev = hsync;
			vs_prev = vsync;
			errors <= errors + bad;
		end
	end

endmodule

/* bench/tunnel_tb.sv */
// one frame is 420000 steps, so each test spans one or two frames of simulated time
`timescale 1ns/100ps
`include "tunnel_config.svh"

module tunnel_tb;
	import tunnel_pkg::*;

	localparam int FRAME_LIMIT = 1200000;

	logic clk;
	logic rst;
	logic pix_en;
	digit_t your_score;
	digit_t their_score;
	color_t color;
	logic hsync;
	logic vsync;
	logic de;
	coord_t pixel_x;
	coord_t pixel_y;
	int errors;
	int teal_count;
	int hs_pulses;
	int vs_pulses;
	int vs_low_steps;
	int de_lines;
	int bad_lines;
	logic run_en;
	logic gap_mode;
	bit timed_out;
	int tests_run;
	int tests_failed;
	int fails;
	int err0;
	int teal0;
	int hs0;
	int vs0;
	int vsl0;
	int del0;
	int bad0;

	tunnel_render uut (.*);
	tunnel_checker u_check (.*);

	always #50 clk = ~clk;

	// pixel strobe, with random gaps when asked
	initial begin
		void'($urandom(32'h5efb9990));
		forever begin
			@(negedge clk);
			if (!run_en)
				pix_en <= 1'b0;
			else if (gap_mode)
				pix_en <= ($urandom % 4) != 0;
			else
				pix_en <= 1'b1;
		end
	end

	task automatic flag_timeout(input string reason);
		$display("%s", reason);
		timed_out = 1'b1;
	endtask

	task automatic wait_frame();
		int cycles;
		bit now_origin;
		bit was_origin;
		cycles = 0;
		now_origin = 1'b1;
		was_origin = 1'b1;
		while ((was_origin || !now_origin) && cycles < FRAME_LIMIT && !timed_out) begin
			@(negedge clk);
			was_origin = now_origin;
			now_origin = (int'(pixel_x) == 0) && (int'(pixel_y) == 0);
			cycles++;
		end
		if (!timed_out && (was_origin || !now_origin))
			flag_timeout("timeout: the outputs never returned to pixel (0,0)");
	endtask

	task automatic wait_row(input int row);
		int cycles;
		cycles = 0;
		while (int'(pixel_y) != row && cycles < FRAME_LIMIT && !timed_out) begin
			@(negedge clk);
			cycles++;
		end
		if (!timed_out && int'(pixel_y) != row)
			flag_timeout("timeout: the requested output row never appeared");
	endtask

	task automatic check_idle(inout int count);
		if (de !== 1'b0) begin
			$display("ERROR t=%0t de expected 0 got %b", $time, de);
			count++;
		end
		if (hsync !== 1'b1 || vsync !== 1'b1) begin
			$display("ERROR t=%0t hsync/vsync expected 1/1 got %b/%b", $time, hsync, vsync);
			count++;
		end
		if (color !== `COLOR_BG) begin
			$display("ERROR t=%0t color expected %06h got %06h", $time, `COLOR_BG, color);
			count++;
		end
	endtask

	task automatic expect_count(input string name, input int got, input int want,
		inout int count);
		if (got != want) begin
			$display("ERROR t=%0t %s expected %0d got %0d", $time, name, want, got);
			count++;
		end
	endtask

	task automatic end_test(input string name, input int count);
		tests_run++;
		if (count != 0 || timed_out) begin
			tests_failed++;
			$display("test %s fail, %0d problems", name, count);
		end else begin
			$display("test %s pass", name);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		pix_en = 1'b0;
		your_score = 4'd3;
		their_score = 4'd7;
		run_en = 1'b0;
		gap_mode = 1'b0;
		timed_out = 1'b0;
		tests_run = 0;
		tests_failed = 0;

		fails = 0;
		repeat (3) begin
			@(negedge clk);
			check_idle(fails);
		end
		rst <= 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_idle(fails);
		end
		end_test("reset", fails);
		run_en <= 1'b1;

		// first full frame after the one that starts out of reset
		wait_frame();
		err0 = errors;
		teal0 = teal_count;
		wait_frame();
		fails = errors - err0;
		if (teal_count == teal0) begin
			$display("no score pixels were drawn for digits 3 and 7");
			fails++;
		end
		end_test("full_frame", fails);

		// change lands inside the glyph rows
		err0 = errors;
		wait_row(20);
		your_score <= 4'd5;
		their_score <= 4'd2;
		wait_frame();
		wait_frame();
		end_test("score_update", errors - err0);

		gap_mode <= 1'b1;
		wait_frame();
		err0 = errors;
		wait_frame();
		gap_mode <= 1'b0;
		end_test("pix_en_gaps", errors - err0);

		your_score <= 4'd10;
		their_score <= 4'd15;
		wait_frame();
		err0 = errors;
		teal0 = teal_count;
		hs0 = hs_pulses;
		vs0 = vs_pulses;
		vsl0 = vs_low_steps;
		del0 = de_lines;
		bad0 = bad_lines;
		wait_frame();
		fails = errors - err0;
		expect_count("teal pixels", teal_count - teal0, 0, fails);
		end_test("blank_digits", fails);

		fails = 0;
		expect_count("hsync pulses", hs_pulses - hs0, `V_TOTAL, fails);
		expect_count("vsync pulses", vs_pulses - vs0, 1, fails);
		expect_count("vsync low steps", vs_low_steps - vsl0, `V_SYNC * `H_TOTAL, fails);
		expect_count("de lines", de_lines - del0, `V_ACTIVE, fails);
		expect_count("de lines of wrong length", bad_lines - bad0, 0, fails);
		end_test("sync_structure", fails);

		if (uut.u_props.fail_count != 0) begin
			$display("%0d assertion failures in the bound properties", uut.u_props.fail_count);
			tests_failed++;
		end
		$display("%0d tests run, %0d failed, %0d pixel mismatches", tests_run, tests_failed, errors);
		if (tests_failed == 0 && !timed_out)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+hw
hw/tunnel_pkg.sv
hw/raster_if.sv
hw/raster_timing.sv
hw/frame_draw.sv
hw/diagonal_draw.sv
hw/glyph_rom.sv
hw/score_draw.sv
hw/tunnel_render.sv
bench/tunnel_props.sv
bench/tunnel_checker.sv
bench/tunnel_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tunnel_tb
FILELIST = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
